//--- logic/harnessPkg.sv
// Harness package
// Shared widths, host opcodes and the 64-bit frame layout

package harnessPkg;

	// ----------------------------------------
	// Widths
	// ----------------------------------------
	localparam int dataWidth = 64;
	localparam int addrWidth = 32;
	localparam int byteWidth = 8;

	// Back-end command encoding
	typedef enum logic [1:0] {
		opWrite = 2'd0,
		opRead = 2'd1
	} harnessOpT;

	// Host opcode bytes, top byte of a command frame
	localparam logic [byteWidth-1:0] opByteWrite = 8'h01;
	localparam logic [byteWidth-1:0] opByteRead = 8'h02;

	// ----------------------------------------
	// One frame, two views
	// ----------------------------------------
	typedef union packed {
		// Command frame layout
		struct packed {
			logic [byteWidth-1:0] opcode;
			logic [23:0] reserved;
			logic [addrWidth-1:0] paddr;
		} cmd;
		// Data frame, plain block word
		logic [dataWidth-1:0] data;
	} harnessFrameU;

endpackage

//--- logic/uartRx.sv
// UART receiver
// Synchronizes the line, samples mid-bit and holds one byte until taken

`timescale 1ns/1ns

module uartRx import harnessPkg::*; #(
	parameter int ClocksPerBit = 868
) (
	input logic Clock,
	input logic arstN,
	input logic uartRxd,
	input logic rxTake,
	output logic [byteWidth-1:0] rxByte,
	output logic rxValid,
	output logic rxOverflow
);

	localparam int CountWidth = $clog2(ClocksPerBit);
	localparam logic [CountWidth-1:0] LastCount = CountWidth'(ClocksPerBit - 1);
	localparam logic [CountWidth-1:0] HalfCount = CountWidth'(ClocksPerBit / 2 - 1);

	// Receiver states
	localparam logic [1:0] stIdle = 2'd0;
	localparam logic [1:0] stStart = 2'd1;
	localparam logic [1:0] stData = 2'd2;
	localparam logic [1:0] stStop = 2'd3;

	logic [1:0] rxSync;
	logic [1:0] rxState;
	logic [CountWidth-1:0] clkCount;
	logic [2:0] bitCount;
	logic [byteWidth-1:0] shiftReg;
	logic bitTick;
	logic byteDone;
	logic holdBusy;

	// Mid-bit sample point for data and stop bits
	assign bitTick = (clkCount == LastCount);
	// Valid stop bit seen at its middle
	assign byteDone = (rxState == stStop) && bitTick && rxSync[1];
	// Holding register still owned by the previous byte
	assign holdBusy = rxValid && !rxTake;

	// ----------------------------------------
	// Bit timing and byte handoff
	// ----------------------------------------
	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			rxSync <= 2'b11;
			rxState <= stIdle;
			clkCount <= '0;
			bitCount <= '0;
			rxValid <= 1'b0;
			rxOverflow <= 1'b0;
		end else begin
			// Two flops against metastability
			rxSync <= {rxSync[0], uartRxd};
			rxOverflow <= 1'b0;
			if (rxTake) begin
				rxValid <= 1'b0;
			end
			case (rxState)
				stIdle: begin
					clkCount <= '0;
					if (!rxSync[1]) begin
						rxState <= stStart;
					end
				end
				stStart: begin
					// Recheck the line at half a bit, drop glitches
					if (clkCount == HalfCount) begin
						clkCount <= '0;
						bitCount <= '0;
						rxState <= rxSync[1] ? stIdle : stData;
					end else begin
						clkCount <= clkCount + 1'b1;
					end
				end
				stData: begin
					if (bitTick) begin
						clkCount <= '0;
						bitCount <= bitCount + 3'd1;
						if (bitCount == 3'd7) begin
							rxState <= stStop;
						end
					end else begin
						clkCount <= clkCount + 1'b1;
					end
				end
				default: begin
					if (bitTick) begin
						clkCount <= '0;
						rxState <= stIdle;
					end else begin
						clkCount <= clkCount + 1'b1;
					end
					// New byte while the old one waits is dropped
					if (byteDone && holdBusy) begin
						rxOverflow <= 1'b1;
					end else if (byteDone) begin
						rxValid <= 1'b1;
					end
				end
			endcase
		end
	end

	// Payload, LSB arrives first
	always_ff @(posedge Clock) begin
		if (rxState == stData && bitTick) begin
			shiftReg <= {rxSync[1], shiftReg[byteWidth-1:1]};
		end
		if (byteDone && !holdBusy) begin
			rxByte <= shiftReg;
		end
	end

	// Front end only takes a byte that is there
	assert property (@(posedge Clock) disable iff (!arstN) rxTake |-> rxValid);

endmodule

//--- logic/uartTx.sv
// UART transmitter
// Frames one byte with start and stop bits, ready only when idle

`timescale 1ns/1ns

module uartTx #(
	parameter int ClocksPerBit = 868
) (
	input logic Clock,
	input logic arstN,
	input logic [7:0] txByte,
	input logic txValid,
	output logic txReady,
	output logic uartTxd
);

	localparam int CountWidth = $clog2(ClocksPerBit);
	localparam logic [CountWidth-1:0] LastCount = CountWidth'(ClocksPerBit - 1);

	logic [9:0] txShift;
	logic [3:0] bitsLeft;
	logic [CountWidth-1:0] clkCount;

	assign txReady = (bitsLeft == 4'd0);
	// Line follows the low end of the shifter
	assign uartTxd = txShift[0];

	// ----------------------------------------
	// Load and shift
	// ----------------------------------------
	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			txShift <= '1;
			bitsLeft <= 4'd0;
			clkCount <= '0;
		end else if (txValid && txReady) begin
			// Stop, data, start; start bit goes out next cycle
			txShift <= {1'b1, txByte, 1'b0};
			bitsLeft <= 4'd10;
			clkCount <= '0;
		end else if (bitsLeft != 4'd0) begin
			if (clkCount == LastCount) begin
				clkCount <= '0;
				// Idle level fills in from the top
				txShift <= {1'b1, txShift[9:1]};
				bitsLeft <= bitsLeft - 4'd1;
			end else begin
				clkCount <= clkCount + 1'b1;
			end
		end
	end

endmodule

//--- logic/harnessFrontEnd.sv
// Harness front end
// Assembles host frames into back-end commands and serializes read data back

`timescale 1ns/1ns

module harnessFrontEnd import harnessPkg::*; (
	input logic Clock,
	input logic arstN,
	input logic [byteWidth-1:0] rxByte,
	input logic rxValid,
	input logic rxOverflow,
	input logic txReady,
	input logic oramCommandReady,
	input logic oramDataInReady,
	input logic [dataWidth-1:0] oramDataOut,
	input logic oramDataOutValid,
	output logic rxTake,
	output logic [byteWidth-1:0] txByte,
	output logic txValid,
	output harnessOpT oramCommand,
	output logic [addrWidth-1:0] oramPAddr,
	output logic oramCommandValid,
	output logic [dataWidth-1:0] oramDataIn,
	output logic oramDataInValid,
	output logic oramDataOutReady,
	output logic errorReceiveOverflow,
	output logic errorReceivePattern
);

	// FSM states
	localparam logic [2:0] stRecvCmd = 3'd0;
	localparam logic [2:0] stRecvData = 3'd1;
	localparam logic [2:0] stIssue = 3'd2;
	localparam logic [2:0] stWaitReturn = 3'd3;
	localparam logic [2:0] stSend = 3'd4;

	logic [2:0] state;
	logic [2:0] byteCount;
	harnessFrameU frame;
	harnessFrameU frameNext;
	logic receiving;
	logic takeByte;
	logic lastByte;
	logic cmdDone;
	logic opKnown;
	logic returnFire;
	logic txFire;

	assign receiving = (state == stRecvCmd) || (state == stRecvData);
	assign takeByte = rxTake && rxValid;
	// Byte count wraps to zero after eight
	assign lastByte = takeByte && (byteCount == 3'd7);
	assign cmdDone = lastByte && (state == stRecvCmd);
	assign returnFire = oramDataOutValid && oramDataOutReady;
	assign txFire = txValid && txReady;

	// New byte enters at the top, so the first byte ends up lowest
	always_comb begin
		frameNext.data = {rxByte, frame.data[dataWidth-1:byteWidth]};
	end

	assign opKnown = (frameNext.cmd.opcode == opByteWrite) ||
		(frameNext.cmd.opcode == opByteRead);

	// Return word leaves LSB first from the same frame register
	assign txByte = frame.data[byteWidth-1:0];
	assign oramDataOutReady = (state == stWaitReturn);

	// ----------------------------------------
	// Control FSM
	// ----------------------------------------
	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			state <= stRecvCmd;
			byteCount <= 3'd0;
			rxTake <= 1'b0;
			txValid <= 1'b0;
			oramCommandValid <= 1'b0;
			oramDataInValid <= 1'b0;
			errorReceiveOverflow <= 1'b0;
			errorReceivePattern <= 1'b0;
		end else begin
			// Take one cycle after valid, once per byte
			rxTake <= receiving && rxValid && !rxTake;
			if (rxOverflow) begin
				errorReceiveOverflow <= 1'b1;
			end
			if (takeByte || txFire) begin
				byteCount <= byteCount + 3'd1;
			end
			case (state)
				stRecvCmd: begin
					if (cmdDone && opKnown) begin
						oramCommandValid <= 1'b1;
						// Write still needs its data frame
						state <= (frameNext.cmd.opcode == opByteWrite) ? stRecvData : stIssue;
					end else if (cmdDone) begin
						// Unknown opcode, frame discarded
						errorReceivePattern <= 1'b1;
					end
				end
				stRecvData: begin
					if (lastByte) begin
						oramDataInValid <= 1'b1;
						state <= stIssue;
					end
				end
				stIssue: begin
					if (oramDataInValid && oramDataInReady) begin
						oramDataInValid <= 1'b0;
					end
					if (oramCommandValid && oramCommandReady) begin
						oramCommandValid <= 1'b0;
						state <= (oramCommand == opRead) ? stWaitReturn : stRecvCmd;
					end
				end
				stWaitReturn: begin
					if (returnFire) begin
						txValid <= 1'b1;
						state <= stSend;
					end
				end
				default: begin
					// Eighth byte handed over, back to listening
					if (txFire && byteCount == 3'd7) begin
						txValid <= 1'b0;
						state <= stRecvCmd;
					end
				end
			endcase
		end
	end

	// ----------------------------------------
	// Frame and channel payloads
	// ----------------------------------------
	always_ff @(posedge Clock) begin
		if (takeByte) begin
			frame <= frameNext;
		end else if (returnFire) begin
			frame.data <= oramDataOut;
		end else if (txFire) begin
			frame.data <= frame.data >> byteWidth;
		end
		if (cmdDone) begin
			oramCommand <= (frameNext.cmd.opcode == opByteWrite) ? opWrite : opRead;
			oramPAddr <= frameNext.cmd.paddr;
		end
		if (lastByte && state == stRecvData) begin
			oramDataIn <= frameNext.data;
		end
	end

	// Command and address frozen while the back end stalls
	assert property (@(posedge Clock) disable iff (!arstN)
		oramCommandValid && !oramCommandReady |=>
		oramCommandValid && $stable(oramCommand) && $stable(oramPAddr));

	// No command overlaps a response in flight
	assert property (@(posedge Clock) disable iff (!arstN)
		(state == stSend) |-> !oramCommandValid);

endmodule

//--- logic/loopbackFifo.sv
// Loopback FIFO
// Circular buffer with valid/ready on both sides

`timescale 1ns/1ns

module loopbackFifo import harnessPkg::*; #(
	parameter int Width = dataWidth,
	parameter int Buffering = 16
) (
	input logic Clock,
	input logic arstN,
	input logic [Width-1:0] inData,
	input logic inValid,
	input logic outReady,
	output logic inAccept,
	output logic [Width-1:0] outData,
	output logic outSend
);

	localparam int PtrWidth = (Buffering > 1) ? $clog2(Buffering) : 1;
	localparam int CountWidth = $clog2(Buffering + 1);
	localparam logic [PtrWidth-1:0] LastSlot = PtrWidth'(Buffering - 1);

	logic [Width-1:0] mem [Buffering];
	logic [PtrWidth-1:0] wrPtr;
	logic [PtrWidth-1:0] rdPtr;
	logic [CountWidth-1:0] count;
	logic push;
	logic pop;

	assign inAccept = (count != CountWidth'(Buffering));
	assign outSend = (count != '0);
	assign outData = mem[rdPtr];
	assign push = inValid && inAccept;
	assign pop = outSend && outReady;

	// ----------------------------------------
	// Pointers and occupancy
	// ----------------------------------------
	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wrPtr <= (wrPtr == LastSlot) ? '0 : wrPtr + 1'b1;
			end
			if (pop) begin
				rdPtr <= (rdPtr == LastSlot) ? '0 : rdPtr + 1'b1;
			end
			// Simultaneous push and pop leave the count alone
			if (push && !pop) begin
				count <= count + 1'b1;
			end else if (pop && !push) begin
				count <= count - 1'b1;
			end
		end
	end

	always_ff @(posedge Clock) begin
		if (push) begin
			mem[wrPtr] <= inData;
		end
	end

	assert property (@(posedge Clock) disable iff (!arstN)
		count <= CountWidth'(Buffering));

endmodule

//--- logic/loopbackOram.sv
// Loopback back end
// Small block store standing in for the ORAM, read data returned through a FIFO

`timescale 1ns/1ns

module loopbackOram import harnessPkg::*; #(
	parameter int OramBlocks = 16,
	parameter int FifoDepth = 16
) (
	input logic Clock,
	input logic arstN,
	input harnessOpT oramCommand,
	input logic [addrWidth-1:0] oramPAddr,
	input logic oramCommandValid,
	input logic [dataWidth-1:0] oramDataIn,
	input logic oramDataInValid,
	input logic oramDataOutReady,
	output logic oramCommandReady,
	output logic oramDataInReady,
	output logic [dataWidth-1:0] oramDataOut,
	output logic oramDataOutValid
);

	localparam int IndexWidth = $clog2(OramBlocks);

	logic [dataWidth-1:0] blocks [OramBlocks];
	logic [IndexWidth-1:0] blockIndex;
	logic isWrite;
	logic commandFire;
	logic writeFire;
	logic readFire;
	logic fifoInAccept;
	logic readPending;
	logic [dataWidth-1:0] readWord;

	// Address taken modulo the store depth
	assign blockIndex = oramPAddr[IndexWidth-1:0];
	assign isWrite = (oramCommand == opWrite);

	// Write needs command and data together
	assign oramDataInReady = oramCommandValid && isWrite;
	// Read waits for FIFO room and an empty push slot
	assign oramCommandReady = isWrite ? oramDataInValid : (fifoInAccept && !readPending);

	assign commandFire = oramCommandValid && oramCommandReady;
	assign writeFire = commandFire && isWrite;
	assign readFire = commandFire && !isWrite;

	// ----------------------------------------
	// Block store
	// ----------------------------------------
	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < OramBlocks; i++) begin
				blocks[i] <= '0;
			end
			readPending <= 1'b0;
		end else begin
			if (writeFire) begin
				blocks[blockIndex] <= oramDataIn;
			end
			// Push lands one cycle after the read is accepted
			readPending <= readFire;
		end
	end

	always_ff @(posedge Clock) begin
		if (readFire) begin
			readWord <= blocks[blockIndex];
		end
	end

	loopbackFifo #(
		.Width(dataWidth),
		.Buffering(FifoDepth)
	) returnFifo (
		.Clock(Clock),
		.arstN(arstN),
		.inData(readWord),
		.inValid(readPending),
		.outReady(oramDataOutReady),
		.inAccept(fifoInAccept),
		.outData(oramDataOut),
		.outSend(oramDataOutValid)
	);

	// Room checked at accept time still holds at the push
	assert property (@(posedge Clock) disable iff (!arstN) readPending |-> fifoInAccept);

endmodule

//--- logic/harnessTop.sv
// Harness top level
// UART host link, frame front end and loopback back end on one clock

`timescale 1ns/1ns

module harnessTop import harnessPkg::*; #(
	parameter int ClocksPerBit = 868,
	parameter int FifoDepth = 16,
	parameter int OramBlocks = 16
) (
	input logic Clock,
	input logic arstN,
	input logic uartRxd,
	output logic uartTxd,
	output logic errorReceiveOverflow,
	output logic errorReceivePattern
);

	// ----------------------------------------
	// UART byte links
	// ----------------------------------------
	logic [byteWidth-1:0] rxByte;
	logic rxValid;
	logic rxTake;
	logic rxOverflow;
	logic [byteWidth-1:0] txByte;
	logic txValid;
	logic txReady;

	// Back-end channels
	harnessOpT oramCommand;
	logic [addrWidth-1:0] oramPAddr;
	logic oramCommandValid;
	logic oramCommandReady;
	logic [dataWidth-1:0] oramDataIn;
	logic oramDataInValid;
	logic oramDataInReady;
	logic [dataWidth-1:0] oramDataOut;
	logic oramDataOutValid;
	logic oramDataOutReady;

	uartRx #(.ClocksPerBit(ClocksPerBit)) receiver (
		.Clock(Clock),
		.arstN(arstN),
		.uartRxd(uartRxd),
		.rxTake(rxTake),
		.rxByte(rxByte),
		.rxValid(rxValid),
		.rxOverflow(rxOverflow)
	);

	uartTx #(.ClocksPerBit(ClocksPerBit)) transmitter (
		.Clock(Clock),
		.arstN(arstN),
		.txByte(txByte),
		.txValid(txValid),
		.txReady(txReady),
		.uartTxd(uartTxd)
	);

	harnessFrontEnd tester (
		.Clock(Clock),
		.arstN(arstN),
		.rxByte(rxByte),
		.rxValid(rxValid),
		.rxOverflow(rxOverflow),
		.txReady(txReady),
		.oramCommandReady(oramCommandReady),
		.oramDataInReady(oramDataInReady),
		.oramDataOut(oramDataOut),
		.oramDataOutValid(oramDataOutValid),
		.rxTake(rxTake),
		.txByte(txByte),
		.txValid(txValid),
		.oramCommand(oramCommand),
		.oramPAddr(oramPAddr),
		.oramCommandValid(oramCommandValid),
		.oramDataIn(oramDataIn),
		.oramDataInValid(oramDataInValid),
		.oramDataOutReady(oramDataOutReady),
		.errorReceiveOverflow(errorReceiveOverflow),
		.errorReceivePattern(errorReceivePattern)
	);

	// Stand-in for the real ORAM back end
	loopbackOram #(
		.OramBlocks(OramBlocks),
		.FifoDepth(FifoDepth)
	) loopback (
		.Clock(Clock),
		.arstN(arstN),
		.oramCommand(oramCommand),
		.oramPAddr(oramPAddr),
		.oramCommandValid(oramCommandValid),
		.oramDataIn(oramDataIn),
		.oramDataInValid(oramDataInValid),
		.oramDataOutReady(oramDataOutReady),
		.oramCommandReady(oramCommandReady),
		.oramDataInReady(oramDataInReady),
		.oramDataOut(oramDataOut),
		.oramDataOutValid(oramDataOutValid)
	);

endmodule

//--- tests/harnessTopTb.sv
// Harness testbench
// UART host model drives frames into the harness and checks the words that come back

`timescale 1ns/1ns

module harnessTopTb import harnessPkg::*;;

	localparam int BitClocks = 16;
	localparam int FifoDepth = 4;
	localparam int OramBlocks = 16;
	localparam int ClockPeriod = 20;
	// Host and response frames over all tests, 8 bytes each
	localparam int FrameCount = 34;
	localparam int TimeoutNs = FrameCount * 8 * 10 * BitClocks * ClockPeriod * 4;

	logic Clock;
	logic arstN;
	logic uartRxd;
	logic uartTxd;
	logic errorReceiveOverflow;
	logic errorReceivePattern;

	logic [31:0] lfsrState;
	// Expected store contents, indexed like the back end
	logic [dataWidth-1:0] model [OramBlocks];

	harnessTop #(
		.ClocksPerBit(BitClocks),
		.FifoDepth(FifoDepth),
		.OramBlocks(OramBlocks)
	) dut_i (
		.Clock(Clock),
		.arstN(arstN),
		.uartRxd(uartRxd),
		.uartTxd(uartTxd),
		.errorReceiveOverflow(errorReceiveOverflow),
		.errorReceivePattern(errorReceivePattern)
	);

	always #(ClockPeriod / 2) Clock = ~Clock;

	// ----------------------------------------
	// Checks and failure
	// ----------------------------------------
	task automatic failRun(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1, "stopping after first error");
	endtask

	task automatic checkData(input string name, input logic [dataWidth-1:0] got,
		input logic [dataWidth-1:0] expected);
		if (got !== expected) begin
			$display("ERROR %s got 0x%h expected 0x%h", name, got, expected);
			failRun("data mismatch");
		end
	endtask

	task automatic checkFlag(input string name, input logic got, input logic expected);
		if (got !== expected) begin
			$display("ERROR %s got 0x%h expected 0x%h", name, got, expected);
			failRun("error flag mismatch");
		end
	endtask

	// x^32 + x^22 + x^2 + x + 1, new bit enters at the bottom
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic randomWord(output logic [dataWidth-1:0] w);
		for (int i = 0; i < dataWidth; i++) begin
			lfsrState = lfsrNext(lfsrState);
			w[i] = lfsrState[0];
		end
	endtask

	function automatic harnessFrameU cmdFrame(input logic [7:0] op,
		input logic [addrWidth-1:0] addr);
		harnessFrameU f;
		f.cmd.opcode = op;
		f.cmd.reserved = '0;
		f.cmd.paddr = addr;
		return f;
	endfunction

	// ----------------------------------------
	// UART host model
	// ----------------------------------------
	task automatic driveBit(input logic b);
		@(negedge Clock);
		uartRxd = b;
		repeat (BitClocks - 1) @(negedge Clock);
	endtask

	task automatic sendByte(input logic [7:0] b);
		driveBit(1'b0);
		for (int i = 0; i < 8; i++) begin
			driveBit(b[i]);
		end
		driveBit(1'b1);
	endtask

	// LSB first on the wire
	task automatic sendFrame(input logic [dataWidth-1:0] f);
		for (int i = 0; i < 8; i++) begin
			sendByte(f[8*i +: 8]);
		end
	endtask

	task automatic recvByte(output logic [7:0] b);
		do begin
			@(negedge Clock);
		end while (uartTxd !== 1'b0);
		// Half a bit to the middle of the start bit
		repeat (BitClocks / 2) @(negedge Clock);
		for (int i = 0; i < 8; i++) begin
			repeat (BitClocks) @(negedge Clock);
			b[i] = uartTxd;
		end
		repeat (BitClocks) @(negedge Clock);
		if (uartTxd !== 1'b1) begin
			failRun("stop bit on uartTxd was not high");
		end
	endtask

	task automatic recvWord(output logic [dataWidth-1:0] w);
		logic [7:0] b;
		for (int i = 0; i < 8; i++) begin
			recvByte(b);
			w[8*i +: 8] = b;
		end
	endtask

	task automatic applyReset;
		@(negedge Clock);
		arstN = 1'b0;
		repeat (8) @(negedge Clock);
		arstN = 1'b1;
		for (int i = 0; i < OramBlocks; i++) begin
			model[i] = '0;
		end
	endtask

	// Command frame then data frame, model follows the modulo index
	task automatic writeBlock(input logic [addrWidth-1:0] addr,
		input logic [dataWidth-1:0] value);
		harnessFrameU f;
		f = cmdFrame(opByteWrite, addr);
		sendFrame(f.data);
		sendFrame(value);
		model[addr % OramBlocks] = value;
	endtask

	// Response may start before the last stop bit ends
	task automatic readBlock(input logic [addrWidth-1:0] addr,
		output logic [dataWidth-1:0] word);
		harnessFrameU f;
		f = cmdFrame(opByteRead, addr);
		fork
			sendFrame(f.data);
			recvWord(word);
		join
	endtask

	// ----------------------------------------
	// Directed tests
	// ----------------------------------------
	task automatic testUnwrittenRead;
		logic [dataWidth-1:0] word;
		readBlock(32'h0000_000B, word);
		checkData("oramDataOut", word, '0);
	endtask

	task automatic testWriteReadBack;
		logic [addrWidth-1:0] addrs [5];
		logic [dataWidth-1:0] value;
		logic [dataWidth-1:0] word;
		addrs = '{32'h0000_0003, 32'h0000_0008, 32'h0000_001F, 32'h0000_0104, 32'hA000_0006};
		for (int i = 0; i < 5; i++) begin
			randomWord(value);
			writeBlock(addrs[i], value);
			readBlock(addrs[i], word);
			checkData("oramDataOut", word, model[addrs[i] % OramBlocks]);
		end
		checkFlag("errorReceiveOverflow", errorReceiveOverflow, 1'b0);
		checkFlag("errorReceivePattern", errorReceivePattern, 1'b0);
	endtask

	task automatic testAliasing;
		logic [dataWidth-1:0] value;
		logic [dataWidth-1:0] word;
		randomWord(value);
		writeBlock(32'h0000_0005 + OramBlocks, value);
		readBlock(32'h0000_0005, word);
		checkData("oramDataOut", word, value);
	endtask

	task automatic testBadOpcode;
		harnessFrameU f;
		logic [dataWidth-1:0] word;
		// Points at block 8, a frame issued as a read would return that word
		f = cmdFrame(8'h7F, 32'h0000_0008);
		sendFrame(f.data);
		checkFlag("errorReceivePattern", errorReceivePattern, 1'b1);
		// First word back belongs to this read of block 3
		readBlock(32'h0000_0003, word);
		checkData("oramDataOut", word, model[3]);
		checkFlag("errorReceivePattern", errorReceivePattern, 1'b1);
		applyReset();
		checkFlag("errorReceivePattern", errorReceivePattern, 1'b0);
	endtask

	task automatic testOverflow;
		harnessFrameU f;
		logic [dataWidth-1:0] value;
		logic [dataWidth-1:0] word;
		randomWord(value);
		writeBlock(32'h0000_0009, value);
		checkFlag("errorReceiveOverflow", errorReceiveOverflow, 1'b0);
		f = cmdFrame(opByteRead, 32'h0000_0009);
		fork
			begin
				sendFrame(f.data);
				// Front end busy sending, second byte finds the holder full
				sendByte(8'hA5);
				sendByte(8'h5A);
				sendByte(8'h3C);
			end
			recvWord(word);
		join
		checkData("oramDataOut", word, value);
		checkFlag("errorReceiveOverflow", errorReceiveOverflow, 1'b1);
	endtask

	// Watchdog
	initial begin
		#(TimeoutNs);
		failRun("watchdog timeout, the tests did not finish in time");
	end

	initial begin
		Clock = 1'b0;
		arstN = 1'b0;
		uartRxd = 1'b1;
		lfsrState = 32'd89611;
		applyReset();
		testUnwrittenRead();
		testWriteReadBack();
		testAliasing();
		testBadOpcode();
		testOverflow();
		$display("TEST PASSED");
		$finish;
	end

endmodule

//--- harnessTop.f
logic/harnessPkg.sv
logic/uartRx.sv
logic/uartTx.sv
logic/harnessFrontEnd.sv
logic/loopbackFifo.sv
logic/loopbackOram.sv
logic/harnessTop.sv
tests/harnessTopTb.sv
